//--- design/stim_pkg.sv
package stim_pkg;

    //////////////////////////////////////////////////
    // waveform memory geometry
    //////////////////////////////////////////////////

    // number of sample slots
    localparam int WAVE_DEPTH = 256;
    // address bits for WAVE_DEPTH slots
    localparam int WAVE_AW = 8;

    // rate half-count width, same as the clock generator input
    localparam int HALF_CNT_W = 18;

    //////////////////////////////////////////////////
    // word types
    //////////////////////////////////////////////////

    // one float length sample or one config word
    typedef logic [31:0] sample_t;
    // one pipe or wire word from the host
    typedef logic [15:0] halfword_t;
    typedef logic [HALF_CNT_W-1:0] half_cnt_t;
    typedef logic [WAVE_AW-1:0] wave_addr_t;
    // one bit wider than the address, holds 0 to WAVE_DEPTH
    typedef logic [WAVE_AW:0] wave_count_t;

    //////////////////////////////////////////////////
    // config register defaults and trigger bits
    //////////////////////////////////////////////////

    localparam half_cnt_t HALF_CNT_RESET = 18'd9;
    // float 0.9
    localparam sample_t PXI_LEN_RESET = 32'h3F66_6666;
    // nonzero picks the fixed length
    localparam sample_t SRC_SEL_RESET = 32'd1;

    localparam int TRIG_HALF_CNT = 0;
    localparam int TRIG_SRC_SEL = 7;
    localparam int TRIG_PXI_LEN = 8;

endpackage

//--- design/wave_if.sv
// producer to buffer, write side
interface wave_wr_if
    import stim_pkg::*;
();
    // one strobe per sample, no ready
    logic       wr_en;
    wave_addr_t wr_addr;
    sample_t    wr_data;
    // drops the loaded-sample count back to zero
    logic       wr_clear;

    modport wr (output wr_en, output wr_addr, output wr_data, output wr_clear);
    modport wr_in (input wr_en, input wr_addr, input wr_data, input wr_clear);
endinterface

// consumer to buffer, read side
interface wave_rd_if
    import stim_pkg::*;
();
    logic        rd_en;
    wave_addr_t  rd_addr;
    // valid the cycle after rd_en
    sample_t     rd_data;
    // how many slots hold loaded samples
    wave_count_t count;

    // requester
    modport rd (output rd_en, output rd_addr, input rd_data, input count);
    // responder
    modport rd_out (input rd_en, input rd_addr, output rd_data, output count);
endinterface

//--- design/trigger_regs.sv
module trigger_regs
    import stim_pkg::*;
(
    input  logic        ep50trig,
    input  logic        reset_global,
    // one bit per register, sampled every cycle
    input  logic [15:0] i_trig,
    input  halfword_t   i_wire_lo,
    input  halfword_t   i_wire_hi,
    output half_cnt_t   o_half_cnt,
    output sample_t     o_src_sel,
    output sample_t     o_pxi_len
);

    // full config word as the host presents it
    sample_t wire_word;

    assign wire_word = {i_wire_hi, i_wire_lo};

    //////////////////////////////////////////////////
    // host loaded registers
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            o_half_cnt <= HALF_CNT_RESET;
            o_src_sel  <= SRC_SEL_RESET;
            o_pxi_len  <= PXI_LEN_RESET;
        end
        else
        begin
            // rate, low wire only, zero-extended to 18 bits
            if (i_trig[TRIG_HALF_CNT])
                o_half_cnt <= half_cnt_t'(i_wire_lo);

            // zero selects the replayed waveform
            if (i_trig[TRIG_SRC_SEL])
                o_src_sel <= wire_word;

            // fixed muscle length as a float word
            if (i_trig[TRIG_PXI_LEN])
                o_pxi_len <= wire_word;
        end
    end

endmodule

//--- design/pipe_word_assembler.sv
module pipe_word_assembler
    import stim_pkg::*;
(
    input  logic      ep50trig,
    input  logic      reset_global,
    input  logic      i_reset_sim,
    input  logic      i_pipe_write,
    input  halfword_t i_pipe_data,
    wave_wr_if.wr     wr
);

    // low half waiting for its partner
    halfword_t   low_half;
    // set while the next pipe word is a high half
    logic        hi_next;
    // next free slot, stops at WAVE_DEPTH
    wave_count_t wr_ptr;
    logic        mem_full;

    assign mem_full = (wr_ptr == wave_count_t'(WAVE_DEPTH));

    //////////////////////////////////////////////////
    // pairing state and write strobe
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            hi_next     <= 1'b0;
            wr_ptr      <= '0;
            wr.wr_en    <= 1'b0;
            wr.wr_clear <= 1'b0;
        end
        else if (i_reset_sim)
        begin
            // restart pairing, tell the ram to forget its samples
            hi_next     <= 1'b0;
            wr_ptr      <= '0;
            wr.wr_en    <= 1'b0;
            wr.wr_clear <= 1'b1;
        end
        else
        begin
            wr.wr_clear <= 1'b0;
            wr.wr_en    <= 1'b0;
            if (i_pipe_write)
            begin
                hi_next <= ~hi_next;
                // high half completes a sample, dropped once full
                if (hi_next && !mem_full)
                begin
                    wr.wr_en <= 1'b1;
                    wr_ptr   <= wr_ptr + wave_count_t'(1);
                end
            end
        end
    end

    // sample payload, low half first on the pipe
    always_ff @(posedge ep50trig)
    begin
        if (i_pipe_write && !hi_next)
            low_half <= i_pipe_data;
        if (i_pipe_write && hi_next)
        begin
            wr.wr_addr <= wr_ptr[WAVE_AW-1:0];
            wr.wr_data <= {i_pipe_data, low_half};
        end
    end

endmodule

//--- design/waveform_ram.sv
module waveform_ram
    import stim_pkg::*;
(
    input  logic      ep50trig,
    input  logic      reset_global,
    wave_wr_if.wr_in  wr_in,
    wave_rd_if.rd_out rd_out
);

    // sample store, one float length per slot
    sample_t     mem [WAVE_DEPTH];
    wave_count_t count_q;

    //////////////////////////////////////////////////
    // memory ports
    //////////////////////////////////////////////////

    // write port, taken on every strobe
    always_ff @(posedge ep50trig)
    begin
        if (wr_in.wr_en)
            mem[wr_in.wr_addr] <= wr_in.wr_data;
    end

    // registered read, same address as a write gives the old word
    always_ff @(posedge ep50trig)
    begin
        if (rd_out.rd_en)
            rd_out.rd_data <= mem[rd_out.rd_addr];
    end

    //////////////////////////////////////////////////
    // loaded-sample count
    //////////////////////////////////////////////////

    // one per write, the producer stops strobing once full
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            count_q <= '0;
        else if (wr_in.wr_clear)
            count_q <= '0;
        else if (wr_in.wr_en)
            count_q <= count_q + wave_count_t'(1);
    end

    // the player wraps its read address on this
    assign rd_out.count = count_q;

endmodule

//--- design/wave_player.sv
module wave_player
    import stim_pkg::*;
(
    input  logic      ep50trig,
    input  logic      reset_global,
    input  logic      i_reset_sim,
    input  half_cnt_t i_half_cnt,
    input  sample_t   i_src_sel,
    input  sample_t   i_pxi_len,
    wave_rd_if.rd     rd,
    output sample_t   o_sample,
    output logic      o_sample_strobe,
    output sample_t   o_muscle_len
);

    // counts 0 to 2*half+1, so one read per 2*(half+1) cycles
    logic [HALF_CNT_W:0] period_cnt;
    // terminal value, latched at each period start
    logic [HALF_CNT_W:0] period_last;
    logic                period_end;
    logic                wave_loaded;
    logic                rd_fire;
    wave_addr_t          rd_addr_q;
    wave_count_t         addr_next;
    logic                addr_wrap;
    // read issued last cycle, data sits in the ram register
    logic                rd_pending;
    sample_t             sample_q;
    logic                strobe_q;

    assign wave_loaded = (rd.count != '0);
    assign period_end  = (period_cnt == period_last);
    assign rd_fire     = wave_loaded && period_end;

    //////////////////////////////////////////////////
    // period counter
    //////////////////////////////////////////////////
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
        begin
            period_cnt  <= '0;
            period_last <= {HALF_CNT_RESET, 1'b1};
        end
        else if (i_reset_sim || !wave_loaded || period_end)
        begin
            // new half-count only taken at a period boundary
            period_cnt  <= '0;
            period_last <= {i_half_cnt, 1'b1};
        end
        else
            period_cnt <= period_cnt + 1'b1;
    end

    //////////////////////////////////////////////////
    // read address, wraps at the loaded count
    //////////////////////////////////////////////////
    assign addr_next = {1'b0, rd_addr_q} + wave_count_t'(1);
    assign addr_wrap = (addr_next >= rd.count);

    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_reset_sim)
            rd_addr_q <= '0;
        else if (rd_fire)
            rd_addr_q <= addr_wrap ? '0 : addr_next[WAVE_AW-1:0];
    end

    assign rd.rd_en   = rd_fire;
    assign rd.rd_addr = rd_addr_q;

    // return tracking, one read in flight at most
    always_ff @(posedge ep50trig)
    begin
        if (reset_global || i_reset_sim)
        begin
            rd_pending <= 1'b0;
            strobe_q   <= 1'b0;
        end
        else
        begin
            rd_pending <= rd_fire;
            strobe_q   <= rd_pending;
        end
    end

    // held until the next return
    always_ff @(posedge ep50trig)
    begin
        if (reset_global)
            sample_q <= '0;
        else if (rd_pending)
            sample_q <= rd.rd_data;
    end

    assign o_sample        = sample_q;
    assign o_sample_strobe = strobe_q;
    // nonzero select gives the host's fixed length
    assign o_muscle_len    = (i_src_sel != '0) ? i_pxi_len : sample_q;

endmodule

//--- design/limb_stim_top.sv
module limb_stim_top
    import stim_pkg::*;
(
    input  logic        ep50trig,
    input  logic        reset_global,
    input  logic        i_reset_sim,
    input  logic [15:0] i_trig,
    input  halfword_t   i_wire_lo,
    input  halfword_t   i_wire_hi,
    input  logic        i_pipe_write,
    input  halfword_t   i_pipe_data,
    output sample_t     o_sample,
    output sample_t     o_muscle_len,
    output logic        o_sample_strobe,
    output wave_count_t o_wave_count
);

    // config words from the host
    half_cnt_t half_cnt;
    sample_t   src_sel;
    sample_t   pxi_len;

    wave_wr_if wr_bus ();
    wave_rd_if rd_bus ();

    //////////////////////////////////////////////////
    // host side
    //////////////////////////////////////////////////
    trigger_regs u_trigger_regs (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_trig       (i_trig),
        .i_wire_lo    (i_wire_lo),
        .i_wire_hi    (i_wire_hi),
        .o_half_cnt   (half_cnt),
        .o_src_sel    (src_sel),
        .o_pxi_len    (pxi_len)
    );

    // pipe halfwords into 32-bit samples
    pipe_word_assembler u_assembler (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .i_reset_sim  (i_reset_sim),
        .i_pipe_write (i_pipe_write),
        .i_pipe_data  (i_pipe_data),
        .wr           (wr_bus.wr)
    );

    //////////////////////////////////////////////////
    // waveform store and replay
    //////////////////////////////////////////////////
    waveform_ram u_waveform_ram (
        .ep50trig     (ep50trig),
        .reset_global (reset_global),
        .wr_in        (wr_bus.wr_in),
        .rd_out       (rd_bus.rd_out)
    );

    wave_player u_wave_player (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .i_reset_sim     (i_reset_sim),
        .i_half_cnt      (half_cnt),
        .i_src_sel       (src_sel),
        .i_pxi_len       (pxi_len),
        .rd              (rd_bus.rd),
        .o_sample        (o_sample),
        .o_sample_strobe (o_sample_strobe),
        .o_muscle_len    (o_muscle_len)
    );

    // loaded-sample count for the host
    assign o_wave_count = rd_bus.count;

endmodule

//--- tests/limb_stim_assert.sv
module limb_stim_assert
    import stim_pkg::*;
(
    input logic        ep50trig,
    input logic        reset_global,
    input logic        i_strobe,
    input logic        i_rd_en,
    input wave_addr_t  i_rd_addr,
    input wave_count_t i_count
);

    //////////////////////////////////////////////////
    // replay side rules
    //////////////////////////////////////////////////

    // strobe is a single-cycle pulse
    strobe_single: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_strobe |=> !i_strobe)
        else $error("sample strobe high for two cycles");

    // read stays inside the loaded samples
    addr_in_range: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_rd_en |-> ({1'b0, i_rd_addr} < i_count))
        else $error("read address not below the loaded count");

    // nothing loaded, nothing read
    no_empty_read: assert property (@(posedge ep50trig) disable iff (reset_global)
        i_rd_en |-> (i_count != '0))
        else $error("read issued with an empty waveform memory");

endmodule

// attach to the player, taps its read port
bind wave_player limb_stim_assert u_player_assert (
    .ep50trig     (ep50trig),
    .reset_global (reset_global),
    .i_strobe     (o_sample_strobe),
    .i_rd_en      (rd.rd_en),
    .i_rd_addr    (rd.rd_addr),
    .i_count      (rd.count)
);

//--- tests/tb_limb_stim.sv
module tb_limb_stim
    import stim_pkg::*;
();

    //////////////////////////////////////////////////
    // DUT signals
    //////////////////////////////////////////////////
    logic        ep50trig;
    logic        reset_global;
    logic        i_reset_sim;
    logic [15:0] i_trig;
    halfword_t   i_wire_lo;
    halfword_t   i_wire_hi;
    logic        i_pipe_write;
    halfword_t   i_pipe_data;
    sample_t     o_sample;
    sample_t     o_muscle_len;
    logic        o_sample_strobe;
    wave_count_t o_wave_count;

    // rate used once the half-count is reloaded
    localparam int      RATE_HALF = 3;
    // float 2.0 as the new fixed length
    localparam sample_t FIXED_LEN = 32'h4000_0000;

    // free running cycle stamp
    int unsigned cyc = 0;
    // xorshift state
    sample_t     rng_state = 32'd25;
    // samples in the order they went down the pipe
    sample_t     written [$];

    limb_stim_top dut0 (
        .ep50trig        (ep50trig),
        .reset_global    (reset_global),
        .i_reset_sim     (i_reset_sim),
        .i_trig          (i_trig),
        .i_wire_lo       (i_wire_lo),
        .i_wire_hi       (i_wire_hi),
        .i_pipe_write    (i_pipe_write),
        .i_pipe_data     (i_pipe_data),
        .o_sample        (o_sample),
        .o_muscle_len    (o_muscle_len),
        .o_sample_strobe (o_sample_strobe),
        .o_wave_count    (o_wave_count)
    );

    initial
    begin
        ep50trig = 1'b0;
        forever #2 ep50trig = ~ep50trig;
    end

    always @(posedge ep50trig)
        cyc <= cyc + 1;

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////
    function automatic sample_t next_random(input sample_t x);
        sample_t y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic end_failed();
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input sample_t got, input sample_t want);
        if (got !== want)
        begin
            $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, want);
            end_failed();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("timeout: %s", what);
        end_failed();
    endtask

    // one-cycle trigger pulse with the word on the wires
    task automatic pulse_trigger(input int bit_idx, input sample_t word);
        @(posedge ep50trig);
        i_trig    <= 16'd1 << bit_idx;
        i_wire_lo <= word[15:0];
        i_wire_hi <= word[31:16];
        @(posedge ep50trig);
        i_trig    <= 16'd0;
        @(negedge ep50trig);
    endtask

    // cleared count reaches the ram two edges after the pulse
    task automatic pulse_sim_reset();
        @(posedge ep50trig);
        i_reset_sim <= 1'b1;
        @(posedge ep50trig);
        i_reset_sim <= 1'b0;
        repeat (2) @(posedge ep50trig);
        @(negedge ep50trig);
    endtask

    // random samples, low half first
    task automatic stream_samples(input int n);
        int      k;
        sample_t word;
        written.delete();
        for (k = 0; k < n; k++)
        begin
            rng_state = next_random(rng_state);
            word = rng_state;
            written.push_back(word);
            @(posedge ep50trig);
            i_pipe_write <= 1'b1;
            i_pipe_data  <= word[15:0];
            @(posedge ep50trig);
            i_pipe_data  <= word[31:16];
        end
        @(posedge ep50trig);
        i_pipe_write <= 1'b0;
        @(negedge ep50trig);
    endtask

    task automatic wait_count(input int n, input int limit);
        int k;
        bit seen;
        seen = 1'b0;
        for (k = 0; k < limit; k++)
        begin
            @(negedge ep50trig);
            if (32'(o_wave_count) == n)
            begin
                seen = 1'b1;
                break;
            end
        end
        if (!seen)
            report_timeout($sformatf("wave count never reached %0d", n));
    endtask

    // returns at the negedge where the strobe is seen
    task automatic wait_strobe(input int limit, output int unsigned stamp);
        int k;
        bit seen;
        seen = 1'b0;
        stamp = 0;
        for (k = 0; k < limit; k++)
        begin
            @(negedge ep50trig);
            if (o_sample_strobe)
            begin
                seen = 1'b1;
                stamp = cyc;
                break;
            end
        end
        if (!seen)
            report_timeout("no sample strobe arrived");
    endtask

    task automatic expect_no_strobe(input int cycles);
        int k;
        for (k = 0; k < cycles; k++)
        begin
            @(negedge ep50trig);
            if (o_sample_strobe)
            begin
                $display("sample strobe seen while no samples are loaded");
                end_failed();
            end
        end
    endtask

    //////////////////////////////////////////////////
    // directed tests
    //////////////////////////////////////////////////
    task automatic check_reset_defaults();
        check_value("o_muscle_len", o_muscle_len, PXI_LEN_RESET);
        check_value("o_wave_count", 32'(o_wave_count), 32'd0);
        check_value("o_sample", o_sample, 32'd0);
        expect_no_strobe(100);
    endtask

    // two full laps over five samples
    task automatic replay_in_order();
        int          k;
        int unsigned stamp;
        pulse_trigger(TRIG_SRC_SEL, 32'd0);
        stream_samples(5);
        wait_count(5, 40);
        for (k = 0; k < 10; k++)
        begin
            wait_strobe(60, stamp);
            check_value("o_sample", o_sample, written[k % 5]);
            check_value("o_muscle_len", o_muscle_len, written[k % 5]);
        end
    endtask

    // first two strobes may still belong to the old rate
    task automatic measure_rate();
        int          k;
        int unsigned s [5];
        // high wire set too, the rate only takes the low wire
        pulse_trigger(TRIG_HALF_CNT, {16'hFFFF, 16'(RATE_HALF)});
        for (k = 0; k < 5; k++)
            wait_strobe(60, s[k]);
        for (k = 2; k < 5; k++)
            check_value("o_sample_strobe spacing", s[k] - s[k-1], 32'(2 * (RATE_HALF + 1)));
    endtask

    task automatic overflow_wrap();
        int          k;
        bit          found;
        int unsigned stamp;
        pulse_sim_reset();
        stream_samples(260);
        wait_count(256, 40);
        repeat (8) @(negedge ep50trig);
        check_value("o_wave_count", 32'(o_wave_count), 32'd256);
        // find the last stored slot, then the lap must restart at 0
        found = 1'b0;
        for (k = 0; k < 300; k++)
        begin
            wait_strobe(40, stamp);
            if (o_sample === written[255])
            begin
                found = 1'b1;
                break;
            end
        end
        if (!found)
            report_timeout("sample 255 was never replayed");
        wait_strobe(40, stamp);
        check_value("o_sample", o_sample, written[0]);
        wait_strobe(40, stamp);
        check_value("o_sample", o_sample, written[1]);
    endtask

    task automatic sim_reset_keeps_config();
        int unsigned s0;
        int unsigned s1;
        pulse_sim_reset();
        check_value("o_wave_count", 32'(o_wave_count), 32'd0);
        expect_no_strobe(60);
        stream_samples(3);
        wait_count(3, 40);
        wait_strobe(60, s0);
        check_value("o_sample", o_sample, written[0]);
        // select still zero, so the length follows the sample
        check_value("o_muscle_len", o_muscle_len, written[0]);
        wait_strobe(60, s1);
        check_value("o_sample", o_sample, written[1]);
        // half-count kept through the sim reset
        check_value("o_sample_strobe spacing", s1 - s0, 32'(2 * (RATE_HALF + 1)));
    endtask

    task automatic fixed_length_select();
        int          k;
        int          j;
        int unsigned stamp;
        pulse_trigger(TRIG_PXI_LEN, FIXED_LEN);
        pulse_trigger(TRIG_SRC_SEL, 32'd1);
        check_value("o_muscle_len", o_muscle_len, FIXED_LEN);
        wait_strobe(60, stamp);
        j = -1;
        for (k = 0; k < 3; k++)
            if (o_sample === written[k])
                j = k;
        if (j < 0)
        begin
            $display("replayed sample is not one of the loaded samples");
            end_failed();
        end
        // replay keeps its order under the fixed length
        for (k = 1; k < 4; k++)
        begin
            wait_strobe(60, stamp);
            check_value("o_sample", o_sample, written[(j + k) % 3]);
            check_value("o_muscle_len", o_muscle_len, FIXED_LEN);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence
    //////////////////////////////////////////////////
    initial
    begin
        reset_global = 1'b1;
        i_reset_sim  = 1'b0;
        i_trig       = 16'd0;
        i_wire_lo    = 16'd0;
        i_wire_hi    = 16'd0;
        i_pipe_write = 1'b0;
        i_pipe_data  = 16'd0;
        repeat (8) @(posedge ep50trig);
        reset_global <= 1'b0;
        @(negedge ep50trig);

        check_reset_defaults();
        replay_in_order();
        measure_rate();
        overflow_wrap();
        sim_reset_keeps_config();
        fixed_length_select();

        $display("Result: PASSED");
        $finish;
    end

endmodule

//--- build.f
design/stim_pkg.sv
design/wave_if.sv
design/trigger_regs.sv
design/pipe_word_assembler.sv
design/waveform_ram.sv
design/wave_player.sv
design/limb_stim_top.sv
tests/limb_stim_assert.sv
tests/tb_limb_stim.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_limb_stim
FILELIST  = build.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Result: PASSED
SOURCES   = $(wildcard design/*.sv) $(wildcard tests/*.sv)

.PHONY: all run clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: $(SIM_BIN)
	-./$(SIM_BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
